// File: common/cpu_config.svh
// word width, register file geometry and reset pc defines for the core
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// data path width
// also the width of pc and of every address the core forms
`define XLEN 32

// register index width
// five bits address x0 to x31
`define REG_ADDR_W 5

// number of architectural integer registers
// x0 is one of these and always reads zero
`define REG_COUNT 32

// pc after reset
// the first fetch happens at this address
`define RESET_PC 32'h8000_0000

`endif

// File: common/cpu_pkg.sv
// word and register index types, operand, alu and next-pc option enums
`include "cpu_config.svh"

package cpu_pkg;

    // one data or address word
    typedef logic [`XLEN-1:0] word_t;

    // one register index
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // operand pair fed to the alu
    typedef enum logic [1:0] {
        alu_src_none    = 2'b00,
        alu_src_pc_imm  = 2'b01,
        alu_src_rs1_rs2 = 2'b10,
        alu_src_rs1_imm = 2'b11
    } alu_src_e;

    // alu operation, link gives a + 4 for jal and jalr
    typedef enum logic [2:0] {
        alu_op_none  = 3'b000,
        alu_op_add   = 3'b001,
        alu_op_and   = 3'b010,
        alu_op_or    = 3'b011,
        alu_op_xor   = 3'b100,
        alu_op_shift = 3'b101,
        alu_op_link  = 3'b110
    } alu_op_e;

    // source of the next pc
    typedef enum logic [1:0] {
        pc_sel_hold     = 2'b00,
        pc_sel_pc_plus4 = 2'b01,
        pc_sel_pc_imm   = 2'b10,
        pc_sel_rs1_imm  = 2'b11
    } pc_sel_e;

endpackage

// File: compile.f
+incdir+common
+incdir+test
common/cpu_pkg.sv
src/idu.sv
src/regfile.sv
exu/alu.sv
exu/exu.sv
exu/pc_unit.sv
src/cpu_top.sv
test/tb_cpu.sv

// File: exu/alu.sv
// alu: add and subtract, logic ops, shifts and the pc + 4 link value
`timescale 1ns/100ps

module alu (
    input  cpu_pkg::alu_op_e op,
    input  cpu_pkg::word_t   a,
    input  cpu_pkg::word_t   b,
    input  logic             alt_op,
    input  logic             unsigned_en,
    output cpu_pkg::word_t   result
);

    logic [4:0] shamt;

    // shift distance from the low five bits of b
    assign shamt = b[4:0];

    always_comb begin
        case (op)
            // alt_op turns add into subtract
            cpu_pkg::alu_op_add: begin
                result = alt_op ? (a - b) : (a + b);
            end
            cpu_pkg::alu_op_and: begin
                result = a & b;
            end
            cpu_pkg::alu_op_or: begin
                result = a | b;
            end
            cpu_pkg::alu_op_xor: begin
                result = a ^ b;
            end
            // left shift unless alt_op
            // right shift is logical with unsigned_en, else arithmetic
            cpu_pkg::alu_op_shift: begin
                if (!alt_op) begin
                    result = a << shamt;
                end else if (unsigned_en) begin
                    result = a >> shamt;
                end else begin
                    result = cpu_pkg::word_t'($signed(a) >>> shamt);
                end
            end
            // return address, a carries the pc
            cpu_pkg::alu_op_link: begin
                result = a + cpu_pkg::word_t'(4);
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// File: exu/exu.sv
// execute block: operand pair selection and writeback value through the alu
`timescale 1ns/100ps

module exu (
    input  cpu_pkg::alu_src_e alu_src,
    input  cpu_pkg::alu_op_e  alu_op,
    input  logic              alt_op,
    input  logic              shamt_en,
    input  logic              unsigned_en,
    input  cpu_pkg::word_t    pc,
    input  cpu_pkg::word_t    rs1_data,
    input  cpu_pkg::word_t    rs2_data,
    input  cpu_pkg::word_t    imm,
    output cpu_pkg::word_t    rd_data
);

    cpu_pkg::word_t op_a;
    cpu_pkg::word_t op_b;

    always_comb begin
        case (alu_src)
            cpu_pkg::alu_src_pc_imm: begin
                op_a = pc;
                op_b = imm;
            end
            cpu_pkg::alu_src_rs1_rs2: begin
                op_a = rs1_data;
                op_b = rs2_data;
            end
            cpu_pkg::alu_src_rs1_imm: begin
                op_a = rs1_data;
                op_b = imm;
            end
            default: begin
                op_a = '0;
                op_b = '0;
            end
        endcase
        // shift immediates use only the shamt field
        if (shamt_en) begin
            op_b = cpu_pkg::word_t'(imm[4:0]);
        end
    end

    alu u_alu (
        .op          (alu_op),
        .a           (op_a),
        .b           (op_b),
        .alt_op      (alt_op),
        .unsigned_en (unsigned_en),
        .result      (rd_data)
    );

endmodule

// File: exu/pc_unit.sv
// pc unit: next-pc selection and the pc register
`timescale 1ns/100ps
`include "cpu_config.svh"

module pc_unit (
    input  logic             clk,
    input  logic             rst_n,
    input  cpu_pkg::pc_sel_e pc_sel,
    input  cpu_pkg::word_t   imm,
    input  cpu_pkg::word_t   rs1_data,
    output cpu_pkg::word_t   pc
);

    cpu_pkg::word_t next_pc;
    cpu_pkg::word_t jalr_target;

    // jalr target before bit 0 is cleared
    assign jalr_target = rs1_data + imm;

    always_comb begin
        case (pc_sel)
            cpu_pkg::pc_sel_pc_plus4: begin
                next_pc = pc + cpu_pkg::word_t'(4);
            end
            cpu_pkg::pc_sel_pc_imm: begin
                next_pc = pc + imm;
            end
            cpu_pkg::pc_sel_rs1_imm: begin
                next_pc = {jalr_target[`XLEN-1:1], 1'b0};
            end
            // hold, unsupported word keeps the pc
            default: begin
                next_pc = pc;
            end
        endcase
    end

    // pc register, one update per rising edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= `RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

    // decoded targets keep the pc on a word boundary
    a_pc_aligned : assert property (
        @(posedge clk) disable iff (!rst_n)
        pc[1:0] == 2'b00
    );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build the core and its testbench with verilator, run it, check the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module tb_cpu \
    -f compile.f \
    -Mdir obj_dir -o Vtb_cpu

# a failing run exits non-zero, the verdict comes from the log below
./obj_dir/Vtb_cpu > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed" sim.log; then
    echo "simulation PASSED"
    exit 0
else
    echo "simulation FAILED"
    exit 1
fi

// File: src/cpu_top.sv
// single-cycle rv32i subset core top: decoder, register file, execute and pc unit
`timescale 1ns/100ps

module cpu_top (
    input  logic               clk,
    input  logic               rst_n,
    input  cpu_pkg::word_t     inst,
    output cpu_pkg::word_t     pc,
    output logic               wb_en,
    output cpu_pkg::reg_addr_t wb_addr,
    output cpu_pkg::word_t     wb_data
);

    // decoder outputs
    cpu_pkg::reg_addr_t rs1;
    cpu_pkg::reg_addr_t rs2;
    cpu_pkg::word_t     imm;
    cpu_pkg::alu_src_e  alu_src;
    cpu_pkg::alu_op_e   alu_op;
    cpu_pkg::pc_sel_e   pc_sel;
    logic               alt_op;
    logic               shamt_en;
    logic               unsigned_en;

    // register read data
    cpu_pkg::word_t rs1_data;
    cpu_pkg::word_t rs2_data;

    // rd and reg_wen go straight out as the writeback trace
    idu u_idu (
        .inst        (inst),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (wb_addr),
        .imm         (imm),
        .reg_wen     (wb_en),
        .alu_src     (alu_src),
        .alu_op      (alu_op),
        .pc_sel      (pc_sel),
        .alt_op      (alt_op),
        .shamt_en    (shamt_en),
        .unsigned_en (unsigned_en)
    );

    regfile u_regfile (
        .clk    (clk),
        .rst_n  (rst_n),
        .wen    (wb_en),
        .waddr  (wb_addr),
        .wdata  (wb_data),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    // writeback value feeds the register file and the trace port
    exu u_exu (
        .alu_src     (alu_src),
        .alu_op      (alu_op),
        .alt_op      (alt_op),
        .shamt_en    (shamt_en),
        .unsigned_en (unsigned_en),
        .pc          (pc),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .imm         (imm),
        .rd_data     (wb_data)
    );

    pc_unit u_pc_unit (
        .clk      (clk),
        .rst_n    (rst_n),
        .pc_sel   (pc_sel),
        .imm      (imm),
        .rs1_data (rs1_data),
        .pc       (pc)
    );

endmodule

// File: src/idu.sv
// instruction decoder: register addresses, immediate and option fields
`timescale 1ns/100ps

module idu (
    input  cpu_pkg::word_t     inst,
    output cpu_pkg::reg_addr_t rs1,
    output cpu_pkg::reg_addr_t rs2,
    output cpu_pkg::reg_addr_t rd,
    output cpu_pkg::word_t     imm,
    output logic               reg_wen,
    output cpu_pkg::alu_src_e  alu_src,
    output cpu_pkg::alu_op_e   alu_op,
    output cpu_pkg::pc_sel_e   pc_sel,
    output logic               alt_op,
    output logic               shamt_en,
    output logic               unsigned_en
);

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_op_imm = 7'b0010011,
        opc_op     = 7'b0110011
    } opcode_e;

    opcode_e        opcode;
    logic [2:0]     funct3;
    logic [6:0]     funct7;
    cpu_pkg::word_t imm_i;
    cpu_pkg::word_t imm_u;
    cpu_pkg::word_t imm_j;
    logic           supported;

    // fixed instruction fields
    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rs2    = inst[24:20];
    assign rd     = inst[11:7];

    // immediates by format, all sign extended from bit 31
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        supported   = 1'b0;
        rs1         = inst[19:15];
        imm         = '0;
        alu_src     = cpu_pkg::alu_src_none;
        alu_op      = cpu_pkg::alu_op_none;
        pc_sel      = cpu_pkg::pc_sel_pc_plus4;
        alt_op      = 1'b0;
        shamt_en    = 1'b0;
        unsigned_en = 1'b0;
        case (opcode)
            // lui is x0 + imm
            opc_lui: begin
                supported = 1'b1;
                rs1       = '0;
                imm       = imm_u;
                alu_src   = cpu_pkg::alu_src_rs1_imm;
                alu_op    = cpu_pkg::alu_op_add;
            end
            opc_auipc: begin
                supported = 1'b1;
                imm       = imm_u;
                alu_src   = cpu_pkg::alu_src_pc_imm;
                alu_op    = cpu_pkg::alu_op_add;
            end
            // link value is pc + 4, target is pc + imm
            opc_jal: begin
                supported = 1'b1;
                imm       = imm_j;
                alu_src   = cpu_pkg::alu_src_pc_imm;
                alu_op    = cpu_pkg::alu_op_link;
                pc_sel    = cpu_pkg::pc_sel_pc_imm;
            end
            // only funct3 000 is a valid jalr
            opc_jalr: begin
                supported = (funct3 == 3'b000);
                imm       = imm_i;
                alu_src   = cpu_pkg::alu_src_pc_imm;
                alu_op    = cpu_pkg::alu_op_link;
                pc_sel    = cpu_pkg::pc_sel_rs1_imm;
            end
            opc_op_imm: begin
                imm     = imm_i;
                alu_src = cpu_pkg::alu_src_rs1_imm;
                case (funct3)
                    3'b000: begin
                        supported = 1'b1;
                        alu_op    = cpu_pkg::alu_op_add;
                    end
                    3'b111: begin
                        supported = 1'b1;
                        alu_op    = cpu_pkg::alu_op_and;
                    end
                    3'b110: begin
                        supported = 1'b1;
                        alu_op    = cpu_pkg::alu_op_or;
                    end
                    3'b100: begin
                        supported = 1'b1;
                        alu_op    = cpu_pkg::alu_op_xor;
                    end
                    // slli needs a zero funct7
                    3'b001: begin
                        supported = (funct7 == 7'b0000000);
                        alu_op    = cpu_pkg::alu_op_shift;
                        shamt_en  = 1'b1;
                    end
                    // srli or srai, funct7 bit 5 picks arithmetic
                    3'b101: begin
                        supported   = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                        alu_op      = cpu_pkg::alu_op_shift;
                        alt_op      = 1'b1;
                        shamt_en    = 1'b1;
                        unsigned_en = ~funct7[5];
                    end
                    default: begin
                        supported = 1'b0;
                    end
                endcase
            end
            opc_op: begin
                alu_src = cpu_pkg::alu_src_rs1_rs2;
                case (funct3)
                    // add or sub
                    3'b000: begin
                        supported = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                        alu_op    = cpu_pkg::alu_op_add;
                        alt_op    = funct7[5];
                    end
                    3'b111: begin
                        supported = (funct7 == 7'b0000000);
                        alu_op    = cpu_pkg::alu_op_and;
                    end
                    3'b110: begin
                        supported = (funct7 == 7'b0000000);
                        alu_op    = cpu_pkg::alu_op_or;
                    end
                    3'b100: begin
                        supported = (funct7 == 7'b0000000);
                        alu_op    = cpu_pkg::alu_op_xor;
                    end
                    3'b001: begin
                        supported = (funct7 == 7'b0000000);
                        alu_op    = cpu_pkg::alu_op_shift;
                    end
                    // srl or sra
                    3'b101: begin
                        supported   = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                        alu_op      = cpu_pkg::alu_op_shift;
                        alt_op      = 1'b1;
                        unsigned_en = ~funct7[5];
                    end
                    default: begin
                        supported = 1'b0;
                    end
                endcase
            end
            default: begin
                supported = 1'b0;
            end
        endcase
        // unsupported word, no write and pc holds
        if (!supported) begin
            imm         = '0;
            alu_src     = cpu_pkg::alu_src_none;
            alu_op      = cpu_pkg::alu_op_none;
            pc_sel      = cpu_pkg::pc_sel_hold;
            alt_op      = 1'b0;
            shamt_en    = 1'b0;
            unsigned_en = 1'b0;
        end
        // writes to x0 are dropped here only
        reg_wen = supported && (rd != '0);
    end

endmodule

// File: src/regfile.sv
// two-read one-write integer register file, x0 reads as zero
`timescale 1ns/100ps
`include "cpu_config.svh"

module regfile (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               wen,
    input  cpu_pkg::reg_addr_t waddr,
    input  cpu_pkg::word_t     wdata,
    input  cpu_pkg::reg_addr_t raddr1,
    input  cpu_pkg::reg_addr_t raddr2,
    output cpu_pkg::word_t     rdata1,
    output cpu_pkg::word_t     rdata2
);

    // x1 to x31, x0 has no storage
    cpu_pkg::word_t regs [1:`REG_COUNT-1];

    // write lands at the rising edge
    // held off while in reset
    always_ff @(posedge clk) begin
        if (rst_n && wen && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // combinational read ports
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    // decoder already drops rd = x0, so no write to x0 ever reaches here
    a_no_x0_write : assert property (
        @(posedge clk) disable iff (!rst_n)
        wen |-> (waddr != '0)
    );

endmodule

// File: test/tb_vectors.svh
// instruction table with expected writeback trace and next pc for the core testbench
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// one row per cycle
// inst, wb_en, wb_addr, wb_data, pc after the rising edge
typedef struct packed {
    cpu_pkg::word_t     inst;
    logic               wb_en;
    cpu_pkg::reg_addr_t wb_addr;
    cpu_pkg::word_t     wb_data;
    cpu_pkg::word_t     next_pc;
} vector_t;

localparam int NUM_VECTORS = 28;

// rows 0 and 1 are independent and may swap, next pc stays by position
vector_t vectors [NUM_VECTORS] = '{
    // lui x1, 0x12345
    '{32'h123450b7, 1'b1, 5'd1,  32'h12345000, 32'h80000004},
    // addi x2, x0, -8
    '{32'hff800113, 1'b1, 5'd2,  32'hfffffff8, 32'h80000008},
    // addi x3, x1, 0x678 / andi x4, x3, 0xf0 / ori x5, x4, 0x505 / xori x6, x5, -1
    '{32'h67808193, 1'b1, 5'd3,  32'h12345678, 32'h8000000c},
    '{32'h0f01f213, 1'b1, 5'd4,  32'h00000070, 32'h80000010},
    '{32'h50526293, 1'b1, 5'd5,  32'h00000575, 32'h80000014},
    '{32'hfff2c313, 1'b1, 5'd6,  32'hfffffa8a, 32'h80000018},
    // addi x0, x1, 5 computes but never writes
    '{32'h00508013, 1'b0, 5'd0,  32'h12345005, 32'h8000001c},
    // add x7, x0, x1 so x0 must still read zero
    '{32'h001003b3, 1'b1, 5'd7,  32'h12345000, 32'h80000020},
    // add x8, x1, x3 / sub x9, x3, x1 / and x10, x3, x6
    '{32'h00308433, 1'b1, 5'd8,  32'h2468a678, 32'h80000024},
    '{32'h401184b3, 1'b1, 5'd9,  32'h00000678, 32'h80000028},
    '{32'h0061f533, 1'b1, 5'd10, 32'h12345208, 32'h8000002c},
    // or x11, x1, x4 / xor x12, x3, x6
    '{32'h0040e5b3, 1'b1, 5'd11, 32'h12345070, 32'h80000030},
    '{32'h0061c633, 1'b1, 5'd12, 32'hedcbacf2, 32'h80000034},
    // slli x13, x3, 4 / srli x14, x2, 8 / srai x15, x2, 2
    '{32'h00419693, 1'b1, 5'd13, 32'h23456780, 32'h80000038},
    '{32'h00815713, 1'b1, 5'd14, 32'h00ffffff, 32'h8000003c},
    '{32'h40215793, 1'b1, 5'd15, 32'hfffffffe, 32'h80000040},
    // sll x16, x1, x4 (by 16) / srl x17, x6, x9 (by 24) / sra x18, x6, x9
    '{32'h00409833, 1'b1, 5'd16, 32'h50000000, 32'h80000044},
    '{32'h009358b3, 1'b1, 5'd17, 32'h000000ff, 32'h80000048},
    '{32'h40935933, 1'b1, 5'd18, 32'hffffffff, 32'h8000004c},
    // auipc x19, 1
    '{32'h00001997, 1'b1, 5'd19, 32'h8000104c, 32'h80000050},
    // jal x20, +16 then jal x21, -8
    '{32'h01000a6f, 1'b1, 5'd20, 32'h80000054, 32'h80000060},
    '{32'hff9ffaef, 1'b1, 5'd21, 32'h80000064, 32'h80000058},
    // jalr x22, 13(x20), target 0x80000061 with bit 0 cleared
    '{32'h00da0b67, 1'b1, 5'd22, 32'h8000005c, 32'h80000060},
    // mul x23 and lw x5 are outside the subset, pc holds
    '{32'h02208bb3, 1'b0, 5'd23, 32'h00000000, 32'h80000060},
    '{32'h00002283, 1'b0, 5'd5,  32'h00000000, 32'h80000060},
    // addi x24, x22, 4 reads back the jalr link
    '{32'h004b0c13, 1'b1, 5'd24, 32'h80000060, 32'h80000064},
    // add x25, x19, x21 wraps past 32 bits
    '{32'h01598cb3, 1'b1, 5'd25, 32'h000010b0, 32'h80000068},
    // sub x26, x18, x17
    '{32'h41190d33, 1'b1, 5'd26, 32'hffffff00, 32'h8000006c}
};

`endif

// File: test/tb_cpu.sv
// single-cycle core testbench with clock, reset, table loop, compare tasks and timeout
`timescale 1ns/100ps
`include "cpu_config.svh"

module tb_cpu;

    logic               clk;
    logic               rst_n;
    cpu_pkg::word_t     inst;
    cpu_pkg::word_t     pc;
    logic               wb_en;
    cpu_pkg::reg_addr_t wb_addr;
    cpu_pkg::word_t     wb_data;

    `include "tb_vectors.svh"

    // reset, table and some slack
    localparam int TIMEOUT_CYCLES = 16 + NUM_VECTORS + 20;

    int          cycle_count = 0;
    int unsigned rand_val;

    cpu_top DUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .inst    (inst),
        .pc      (pc),
        .wb_en   (wb_en),
        .wb_addr (wb_addr),
        .wb_data (wb_data)
    );

    // 4 ns clock
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run();
        $display("Some tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compare_word(string name, cpu_pkg::word_t expected, cpu_pkg::word_t actual);
        if (actual !== expected) begin
            $display("[ERROR] t=%0t %s expected %h actual %h", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_addr(string name, cpu_pkg::reg_addr_t expected,
                              cpu_pkg::reg_addr_t actual);
        if (actual !== expected) begin
            $display("[ERROR] t=%0t %s expected %0d actual %0d", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic verify_bit(string name, logic expected, logic actual);
        if (actual !== expected) begin
            $display("[ERROR] t=%0t %s expected %b actual %b", $time, name, expected, actual);
            abort_run();
        end
    endtask

    // exchange the two init rows
    // pc column stays with the row position
    task automatic swap_init_entries();
        vector_t        tmp;
        cpu_pkg::word_t pc0;
        cpu_pkg::word_t pc1;
        pc0        = vectors[0].next_pc;
        pc1        = vectors[1].next_pc;
        tmp        = vectors[0];
        vectors[0] = vectors[1];
        vectors[1] = tmp;
        vectors[0].next_pc = pc0;
        vectors[1].next_pc = pc1;
    endtask

    // watchdog
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    initial begin
        rst_n    = 1'b0;
        inst     = '0;
        rand_val = $urandom(32'h2ba);
        // random order of the two register init rows
        rand_val = $urandom();
        if (rand_val[0]) begin
            swap_init_entries();
        end

        // inst = 0 decodes as unsupported during reset
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #1;
        compare_word("pc", `RESET_PC, pc);
        verify_bit("wb_en", 1'b0, wb_en);
        // zero word holds the pc over one edge
        @(posedge clk);
        #1;
        compare_word("pc", `RESET_PC, pc);
        verify_bit("wb_en", 1'b0, wb_en);

        // one row per cycle
        for (int i = 0; i < NUM_VECTORS; i++) begin
            @(negedge clk);
            inst = vectors[i].inst;
            #1;
            verify_bit("wb_en", vectors[i].wb_en, wb_en);
            check_addr("wb_addr", vectors[i].wb_addr, wb_addr);
            compare_word("wb_data", vectors[i].wb_data, wb_data);
            @(posedge clk);
            #1;
            compare_word("pc", vectors[i].next_pc, pc);
        end

        $display("All tests passed");
        $finish;
    end

endmodule
